/* source/guide_config.svh */
`ifndef GUIDE_CONFIG_SVH
`define GUIDE_CONFIG_SVH

// Simulation-scale timing, a board build only swaps these values

// Heartbeat period in clocks (a 20 Hz tick on hardware)
`define GUIDE_TICK_CYCLES     4000

// Clocks a switch must hold still before its new value is taken
`define GUIDE_DEBOUNCE_CYCLES 8

// UART bit length in clocks
`define GUIDE_CLKS_PER_BIT    8

// Phase lengths of the avoidance curve, in heartbeat ticks
`define GUIDE_BACK_TICKS      3
`define GUIDE_R1_TICKS        2
`define GUIDE_L_TICKS         4
`define GUIDE_R2_TICKS        2

// Stop time at a zebra crossing, in ticks
`define GUIDE_ZEBRA_TICKS     3

`endif

/* source/guide_ctrl_pkg.sv */
package guide_ctrl_pkg;

  // Switch and sensor levels, all active high
  typedef struct packed {
    logic start;       // Start whistle
    logic obstacle;    // Front stop level
    logic zebra;       // Zebra crossing seen
    logic person_far;  // Back stop level, handler fell behind
    logic clap;        // Stop by clap
    logic estop;       // Emergency stop
  } guide_inputs_t;

  // Motion command sent to the rover base
  typedef enum logic [2:0] {
    CMD_STOP  = 3'd0,
    CMD_FWD   = 3'd1,
    CMD_ARC_L = 3'd2,
    CMD_ARC_R = 3'd3,
    CMD_REV   = 3'd4
  } guide_cmd_e;

  // Guide behavior states
  typedef enum logic [2:0] {
    S_IDLE    = 3'd0,  // Waiting for start
    S_FORWARD = 3'd1,
    S_BACK    = 3'd2,  // First leg of the avoidance curve
    S_ARC_R1  = 3'd3,
    S_ARC_L   = 3'd4,
    S_ARC_R2  = 3'd5,
    S_ZEBRA   = 3'd6,  // Timed stop at a crossing
    S_HOLD    = 3'd7   // Wait for the handler to catch up
  } guide_state_e;

endpackage

/* source/serial_frame_pkg.sv */
package serial_frame_pkg;

  // Sections of one JSON wheel-speed line
  typedef enum logic [2:0] {
    F_IDLE  = 3'd0,  // No burst running
    F_HEAD  = 3'd1,  // {"T":1,"L":
    F_LEFT  = 3'd2,  // Left wheel value
    F_MID   = 3'd3,  // ,"R":
    F_RIGHT = 3'd4,  // Right wheel value
    F_TAIL  = 3'd5   // Closing brace and line feed
  } frame_field_e;

  // One byte on its way to the UART
  typedef struct packed {
    logic       valid;  // Byte is on offer, held until ready
    logic [7:0] data;
  } serial_byte_t;

endpackage

/* source/input_conditioner.sv */
`timescale 1ns/1ps

`include "guide_config.svh"

module input_conditioner import guide_ctrl_pkg::*; (
  input  logic          CLOCK_50,
  input  logic          rst_n,
  input  logic          tick,       // Heartbeat pulse
  input  guide_inputs_t raw,        // Switches straight from the pins
  output guide_inputs_t level,      // Debounced levels
  output logic          start_req   // Start press waiting for the FSM
);

  localparam int DEB_N = `GUIDE_DEBOUNCE_CYCLES;
  localparam int CNT_W = $clog2(DEB_N + 1);

  logic [5:0] raw_v;
  logic [5:0] lvl_v;
  logic       start_q;    // Debounced start one clock ago
  logic       start_rise;

  assign raw_v = raw;

  // One stability counter per field
  for (genvar i = 0; i < 6; i++) begin : g_deb
    logic [CNT_W-1:0] cnt;
    logic             stable_q;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
      if (!rst_n) begin
        cnt      <= '0;
        stable_q <= 1'b0;
      end else if (raw_v[i] == stable_q) begin
        cnt <= '0;                          // Input agrees, nothing pending
      end else if (cnt == CNT_W'(DEB_N - 1)) begin
        stable_q <= raw_v[i];               // Held long enough, accept it
        cnt      <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end

    assign lvl_v[i] = stable_q;
  end

  assign level = guide_inputs_t'(lvl_v);

  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n) start_q <= 1'b0;
    else        start_q <= level.start;
  end

  assign start_rise = level.start & ~start_q;

  // Sticky request, a press between ticks is kept until the FSM sees it
  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n)          start_req <= 1'b0;
    else if (start_rise) start_req <= 1'b1;  // A fresh press wins over the clear
    else if (tick)       start_req <= 1'b0;
  end

endmodule

/* source/guide_timer.sv */
`timescale 1ns/1ps

`include "guide_config.svh"

module guide_timer (
  input  logic       CLOCK_50,
  input  logic       rst_n,
  input  logic       load,        // Start a new phase
  input  logic [3:0] length,      // Phase length in ticks
  output logic       tick,        // One-cycle heartbeat pulse
  output logic       phase_done   // Phase count has run out
);

  localparam int TICK_N = `GUIDE_TICK_CYCLES;
  localparam int DIV_W  = $clog2(TICK_N);

  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       phase_cnt;

  // Free-running heartbeat divider
  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else begin
      tick <= (div_cnt == DIV_W'(TICK_N - 1));  // Registered, first pulse N clocks in
      if (div_cnt == DIV_W'(TICK_N - 1)) div_cnt <= '0;
      else                               div_cnt <= div_cnt + 1'b1;
    end
  end

  // Phase countdown
  // The FSM loads in a tick cycle, so that tick already counts as the first one
  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n) begin
      phase_cnt <= 4'd0;
    end else if (load) begin
      phase_cnt <= (length == 4'd0) ? 4'd0 : length - 4'd1;
    end else if (tick && phase_cnt != 4'd0) begin
      phase_cnt <= phase_cnt - 4'd1;
    end
  end

  assign phase_done = (phase_cnt == 4'd0);

endmodule

/* source/guide_fsm.sv */
`timescale 1ns/1ps

`include "guide_config.svh"

module guide_fsm import guide_ctrl_pkg::*; (
  input  logic          CLOCK_50,
  input  logic          rst_n,
  input  logic          tick,        // Heartbeat, the only time anything moves
  input  guide_inputs_t level,       // Debounced sensor levels
  input  logic          start_req,   // Pending start press
  input  logic          phase_done,  // Timed phase has run out
  output logic          load,        // Load the phase countdown
  output logic [3:0]    length,      // Ticks for the phase being entered
  output guide_cmd_e    command
);

  guide_state_e state_q;
  guide_state_e next_state;

  // Tick count of each timed state, zero for the untimed ones
  function automatic logic [3:0] phase_len(guide_state_e st);
    case (st)
      S_BACK:   phase_len = 4'(`GUIDE_BACK_TICKS);
      S_ARC_R1: phase_len = 4'(`GUIDE_R1_TICKS);
      S_ARC_L:  phase_len = 4'(`GUIDE_L_TICKS);
      S_ARC_R2: phase_len = 4'(`GUIDE_R2_TICKS);
      S_ZEBRA:  phase_len = 4'(`GUIDE_ZEBRA_TICKS);
      default:  phase_len = 4'd0;
    endcase
  endfunction

  // Wheel command for each state
  function automatic guide_cmd_e cmd_of(guide_state_e st);
    case (st)
      S_FORWARD:          cmd_of = CMD_FWD;
      S_BACK:             cmd_of = CMD_REV;
      S_ARC_R1, S_ARC_R2: cmd_of = CMD_ARC_R;
      S_ARC_L:            cmd_of = CMD_ARC_L;
      default:            cmd_of = CMD_STOP;  // Idle, hold and zebra
    endcase
  endfunction

  always_comb begin
    next_state = state_q;
    load       = 1'b0;
    length     = 4'd0;
    if (tick) begin
      if (level.estop || level.clap) begin
        next_state = S_IDLE;              // Stop wins from any state
      end else begin
        case (state_q)
          S_IDLE:    if (start_req) next_state = S_FORWARD;
          S_FORWARD: begin
            if (level.person_far)    next_state = S_HOLD;
            else if (level.obstacle) next_state = S_BACK;
            else if (level.zebra)    next_state = S_ZEBRA;
          end
          S_HOLD:    if (!level.person_far) next_state = S_FORWARD;
          S_BACK:    if (phase_done) next_state = S_ARC_R1;
          S_ARC_R1:  if (phase_done) next_state = S_ARC_L;
          S_ARC_L:   if (phase_done) next_state = S_ARC_R2;
          S_ARC_R2,
          S_ZEBRA:   if (phase_done) next_state = S_FORWARD;
          default:   next_state = S_IDLE;
        endcase
      end
      // Entering a timed state starts its countdown
      if (next_state != state_q) begin
        length = phase_len(next_state);
        load   = (length != 4'd0);
      end
    end
  end

  // Command follows the state one tick later, it shows where the dog was
  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      command <= CMD_STOP;
    end else if (tick) begin
      state_q <= next_state;
      command <= cmd_of(state_q);
    end
  end

endmodule

/* source/json_burst.sv */
`timescale 1ns/1ps

module json_burst import guide_ctrl_pkg::*, serial_frame_pkg::*; (
  input  logic         CLOCK_50,
  input  logic         rst_n,
  input  logic         tick,      // Heartbeat, one line per tick
  input  guide_cmd_e   command,   // Current motion command
  output serial_byte_t tx,        // Byte stream to the UART
  input  logic         ready      // UART can take a byte
);

  localparam logic [8*11-1:0] HEAD_TXT = "{\"T\":1,\"L\":";
  localparam logic [8*5-1:0]  MID_TXT  = ",\"R\":";
  localparam logic [8*2-1:0]  TAIL_TXT = "}\n";

  frame_field_e field_q;
  logic [3:0]   idx_q;       // Byte index inside the current field
  logic [3:0]   field_len;
  guide_cmd_e   cmd_q;       // Command frozen for the whole line
  logic         tick_d;
  logic         xfer;

  // Tenths digit of the wheel speed
  function automatic logic [7:0] tenths(guide_cmd_e cmd, logic right);
    case (cmd)
      CMD_FWD, CMD_REV: tenths = "2";
      CMD_ARC_L:        tenths = right ? "3" : "1";  // Left wheel slower
      CMD_ARC_R:        tenths = right ? "1" : "3";
      default:          tenths = "0";
    endcase
  endfunction

  // Characters in the value text, "0", "0.d" or "-0.d"
  function automatic logic [7:0] value_char(guide_cmd_e cmd, logic right, logic [3:0] idx);
    logic [3:0] pos;
    pos = (cmd == CMD_REV) ? idx : idx + 4'd1;  // Skip the sign slot
    case (pos)
      4'd0:    value_char = "-";
      4'd1:    value_char = "0";
      4'd2:    value_char = ".";
      default: value_char = tenths(cmd, right);
    endcase
  endfunction

  function automatic logic [3:0] value_len(guide_cmd_e cmd);
    case (cmd)
      CMD_STOP: value_len = 4'd1;
      CMD_REV:  value_len = 4'd4;
      default:  value_len = 4'd3;
    endcase
  endfunction

  always_comb begin
    case (field_q)
      F_HEAD:  field_len = 4'd11;
      F_MID:   field_len = 4'd5;
      F_TAIL:  field_len = 4'd2;
      default: field_len = value_len(cmd_q);  // Both wheels share the length
    endcase
  end

  // Byte on offer, first character sits in the top byte of each text
  always_comb begin
    tx.valid = (field_q != F_IDLE);
    case (field_q)
      F_HEAD:  tx.data = HEAD_TXT[8*(10 - idx_q) +: 8];
      F_LEFT:  tx.data = value_char(cmd_q, 1'b0, idx_q);
      F_MID:   tx.data = MID_TXT[8*(4 - idx_q) +: 8];
      F_RIGHT: tx.data = value_char(cmd_q, 1'b1, idx_q);
      F_TAIL:  tx.data = TAIL_TXT[8*(1 - idx_q) +: 8];
      default: tx.data = 8'h00;
    endcase
  end

  assign xfer = tx.valid && ready;

  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n) begin
      tick_d  <= 1'b0;
      field_q <= F_IDLE;
      idx_q   <= 4'd0;
    end else begin
      tick_d <= tick;
      if (field_q == F_IDLE) begin
        if (tick_d) begin                 // Command has settled by now
          field_q <= F_HEAD;
          idx_q   <= 4'd0;
        end
      end else if (xfer) begin
        if (idx_q == field_len - 4'd1) begin
          idx_q   <= 4'd0;
          field_q <= (field_q == F_TAIL) ? F_IDLE : frame_field_e'(field_q + 3'd1);
        end else begin
          idx_q <= idx_q + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (field_q == F_IDLE && tick_d) cmd_q <= command;
  end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

`include "guide_config.svh"

module uart_tx import serial_frame_pkg::*; #(
  parameter int CLKS_PER_BIT = `GUIDE_CLKS_PER_BIT
) (
  input  logic         CLOCK_50,
  input  logic         rst_n,
  input  serial_byte_t tx,        // Byte offered by the burst generator
  output logic         ready,     // Idle, next byte can be taken
  output logic         uart_out   // Serial line, idles high
);

  localparam int BAUD_W = $clog2(CLKS_PER_BIT);

  logic              busy;
  logic [9:0]        shift_q;     // Stop, data, start, sent from bit 0
  logic [3:0]        bit_cnt;
  logic [BAUD_W-1:0] baud_cnt;

  assign ready    = ~busy;
  assign uart_out = busy ? shift_q[0] : 1'b1;

  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      bit_cnt  <= 4'd0;
      baud_cnt <= '0;
    end else if (!busy) begin
      if (tx.valid) begin                   // Transfer, start bit follows next clock
        busy     <= 1'b1;
        bit_cnt  <= 4'd0;
        baud_cnt <= '0;
      end
    end else if (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1)) begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd9) busy <= 1'b0;    // End of stop bit
      else                 bit_cnt <= bit_cnt + 4'd1;
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Frame register, LSB first behind the start bit
  always_ff @(posedge CLOCK_50) begin
    if (!busy && tx.valid)
      shift_q <= {1'b1, tx.data, 1'b0};
    else if (busy && baud_cnt == BAUD_W'(CLKS_PER_BIT - 1))
      shift_q <= {1'b1, shift_q[9:1]};
  end

endmodule

/* source/guide_dog_top.sv */
`timescale 1ns/1ps

module guide_dog_top import guide_ctrl_pkg::*, serial_frame_pkg::*; (
  input  logic          CLOCK_50,
  input  logic          rst_n,
  input  guide_inputs_t sensors,   // Switches plus the front and back stop levels
  output guide_cmd_e    command,
  output logic          uart_out   // To the rover base RX
);

  guide_inputs_t level;
  logic          start_req;
  logic          tick;
  logic          load;
  logic [3:0]    length;
  logic          phase_done;
  serial_byte_t  tx_byte;
  logic          tx_ready;

  input_conditioner u_cond (
    .CLOCK_50  (CLOCK_50),
    .rst_n     (rst_n),
    .tick      (tick),
    .raw       (sensors),
    .level     (level),
    .start_req (start_req)
  );

  guide_timer u_timer (
    .CLOCK_50   (CLOCK_50),
    .rst_n      (rst_n),
    .load       (load),
    .length     (length),
    .tick       (tick),
    .phase_done (phase_done)
  );

  guide_fsm u_fsm (
    .CLOCK_50   (CLOCK_50),
    .rst_n      (rst_n),
    .tick       (tick),
    .level      (level),
    .start_req  (start_req),
    .phase_done (phase_done),
    .load       (load),
    .length     (length),
    .command    (command)
  );

  json_burst u_burst (
    .CLOCK_50 (CLOCK_50),
    .rst_n    (rst_n),
    .tick     (tick),
    .command  (command),
    .tx       (tx_byte),
    .ready    (tx_ready)
  );

  uart_tx u_uart (
    .CLOCK_50 (CLOCK_50),
    .rst_n    (rst_n),
    .tx       (tx_byte),
    .ready    (tx_ready),
    .uart_out (uart_out)
  );

endmodule

/* dv/guide_dog_tb.sv */
`timescale 1ns/1ps

`include "guide_config.svh"

module guide_dog_tb import guide_ctrl_pkg::*; ();

  localparam int BIT_CLKS   = `GUIDE_CLKS_PER_BIT;
  localparam int WAIT_LIMIT = 2 * `GUIDE_TICK_CYCLES;  // Clocks to wait for any start bit

  logic          CLOCK_50 = 1'b0;
  logic          rst_n;
  guide_inputs_t sens;
  guide_cmd_e    command;
  logic          uart_out;

  logic [31:0]   rng = 32'h127cc695;
  guide_state_e  m_state;        // Model state after the last tick
  int            m_left;         // Ticks still to go in a timed phase
  logic          start_pending;  // Press made since the last tick
  int            line_no = 0;

  guide_dog_top UUT (
    .CLOCK_50 (CLOCK_50),
    .rst_n    (rst_n),
    .sensors  (sens),
    .command  (command),
    .uart_out (uart_out)
  );

  always #20 CLOCK_50 = ~CLOCK_50;  // 40 ns period

  task automatic abort_run(string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_command(string name, guide_cmd_e got, guide_cmd_e exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %0t %s got %s expected %s", $time, name,
                          got.name(), exp.name()));
  endtask

  task automatic match_byte(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %0t %s got 8'h%02h expected 8'h%02h", $time, name, got, exp));
  endtask

  task automatic verify_length(string name, int got, int exp);
    if (got != exp)
      abort_run($sformatf("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp));
  endtask

  function automatic logic [31:0] next_random();
    rng = rng * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
    return rng;
  endfunction

  // Reference model
  function automatic guide_cmd_e state_command(guide_state_e st);
    case (st)
      S_FORWARD:          return CMD_FWD;
      S_BACK:             return CMD_REV;
      S_ARC_R1, S_ARC_R2: return CMD_ARC_R;
      S_ARC_L:            return CMD_ARC_L;
      default:            return CMD_STOP;  // Idle, hold, zebra
    endcase
  endfunction

  function automatic int phase_ticks(guide_state_e st);
    case (st)
      S_BACK:   return `GUIDE_BACK_TICKS;
      S_ARC_R1: return `GUIDE_R1_TICKS;
      S_ARC_L:  return `GUIDE_L_TICKS;
      S_ARC_R2: return `GUIDE_R2_TICKS;
      S_ZEBRA:  return `GUIDE_ZEBRA_TICKS;
      default:  return 0;                   // Untimed states
    endcase
  endfunction

  function automatic string wheel_text(guide_cmd_e c, bit right);
    case (c)
      CMD_FWD:   return "0.2";
      CMD_ARC_L: return right ? "0.3" : "0.1";
      CMD_ARC_R: return right ? "0.1" : "0.3";
      CMD_REV:   return "-0.2";
      default:   return "0";
    endcase
  endfunction

  function automatic string line_text(guide_cmd_e c);
    return $sformatf("{\"T\":1,\"L\":%s,\"R\":%s}\n", wheel_text(c, 1'b0), wheel_text(c, 1'b1));
  endfunction

  // One heartbeat of the guide rules
  task automatic model_step(guide_inputs_t in, logic sreq);
    guide_state_e nxt;
    nxt = m_state;
    if (in.estop || in.clap) begin
      nxt = S_IDLE;                       // Stop beats everything
    end else begin
      case (m_state)
        S_IDLE: if (sreq) nxt = S_FORWARD;
        S_FORWARD: begin
          if (in.person_far)    nxt = S_HOLD;
          else if (in.obstacle) nxt = S_BACK;
          else if (in.zebra)    nxt = S_ZEBRA;
        end
        S_HOLD: if (!in.person_far) nxt = S_FORWARD;
        default: begin                    // Timed phases
          m_left = m_left - 1;
          if (m_left == 0) begin
            case (m_state)
              S_BACK:   nxt = S_ARC_R1;
              S_ARC_R1: nxt = S_ARC_L;
              S_ARC_L:  nxt = S_ARC_R2;
              default:  nxt = S_FORWARD;
            endcase
          end
        end
      endcase
    end
    if (nxt != m_state) begin
      m_state = nxt;
      m_left  = phase_ticks(nxt);
    end
  endtask

  // Serial decoder, samples at mid bit, returns on a negedge
  task automatic decode_byte(output logic [7:0] b);
    int n;
    n = 0;
    b = 8'h00;
    do begin
      @(negedge CLOCK_50);
      n++;
      if (n > WAIT_LIMIT) abort_run("Timeout while waiting for a start bit on uart_out");
    end while (uart_out !== 1'b0);
    repeat (BIT_CLKS / 2 - 1) @(negedge CLOCK_50);
    if (uart_out !== 1'b0) abort_run("Start bit on uart_out ended early");
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge CLOCK_50);
      b[i] = uart_out;                    // LSB first
    end
    repeat (BIT_CLKS) @(negedge CLOCK_50);
    if (uart_out !== 1'b1) abort_run("Stop bit on uart_out is missing");
  endtask

  // Receive one line, check it, then advance the model
  task automatic take_line();
    logic [7:0] q[$];
    logic [7:0] b;
    guide_cmd_e exp_cmd;
    string      exp_txt;
    exp_cmd = state_command(m_state);     // Line shows the state before the last tick
    exp_txt = line_text(exp_cmd);
    do begin
      decode_byte(b);
      q.push_back(b);
    end while (b != 8'h0a && q.size() < 32);
    verify_length($sformatf("line %0d length", line_no), q.size(), exp_txt.len());
    foreach (q[i]) begin
      match_byte($sformatf("line %0d byte %0d", line_no, i), q[i], exp_txt[i]);
    end
    expect_command("command", command, exp_cmd);
    model_step(sens, start_pending);      // Inputs seen at this line's tick
    start_pending = 1'b0;
    line_no++;
  endtask

  task automatic play(int n);
    repeat (n) take_line();
  endtask

  task automatic drive_inputs(guide_inputs_t v);
    @(negedge CLOCK_50);
    sens = v;
  endtask

  // Short press, well under one heartbeat
  task automatic press_start();
    @(negedge CLOCK_50);
    sens.start = 1'b1;
    repeat (20) @(negedge CLOCK_50);
    sens.start = 1'b0;
    start_pending = 1'b1;
  endtask

  initial begin
    guide_inputs_t v;
    logic [31:0]   r;
    int            hold;
    sens          = '0;
    rst_n         = 1'b0;
    m_state       = S_IDLE;
    m_left        = 0;
    start_pending = 1'b0;
    repeat (8) @(negedge CLOCK_50);
    rst_n = 1'b1;
    @(negedge CLOCK_50);
    if (uart_out !== 1'b1) abort_run("uart_out is not idle high after reset");
    expect_command("command", command, CMD_STOP);
    play(3);                              // Idle, stop lines only

    press_start();
    play(3);                              // Stop, then forward

    v = sens;                             // Obstacle pulse for one line
    v.obstacle = 1'b1;
    drive_inputs(v);
    play(1);
    v.obstacle = 1'b0;
    drive_inputs(v);
    play(13);                             // 3 + 2 + 4 + 2 curve lines, then forward

    v.zebra = 1'b1;
    drive_inputs(v);
    play(1);
    v.zebra = 1'b0;
    drive_inputs(v);
    play(5);

    v.person_far = 1'b1;                  // Handler falls behind for a while
    drive_inputs(v);
    play(4);
    v.person_far = 1'b0;
    drive_inputs(v);
    play(3);

    v.estop = 1'b1;
    drive_inputs(v);
    play(2);
    v.estop = 1'b0;
    drive_inputs(v);
    play(2);                              // Still stopped without a new press
    press_start();
    play(3);

    v.obstacle = 1'b1;                    // Clap in the middle of the curve
    drive_inputs(v);
    play(1);
    v.obstacle = 1'b0;
    drive_inputs(v);
    play(2);
    v.clap = 1'b1;
    drive_inputs(v);
    play(2);
    v.clap = 1'b0;
    drive_inputs(v);
    play(2);
    press_start();
    play(3);

    hold = 0;
    for (int n = 0; n < 60; n++) begin
      if (hold == 0) begin
        r = next_random();
        v = '0;
        v.estop      = (r[11:8] == 4'd0);   // Rare stops
        v.clap       = (r[15:12] == 4'd0);
        v.person_far = (r[18:16] == 3'd0);
        v.obstacle   = (r[21:19] < 3'd2);
        v.zebra      = (r[24:22] < 3'd2);
        drive_inputs(v);
        if (r[27:25] < 3'd3) press_start();
        hold = 1 + int'(r[31:28]) % 3;      // Held for one to three lines
      end
      take_line();
      hold--;
    end

    $display("Lines checked: %0d", line_no);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* sim.f */
+incdir+source
source/guide_ctrl_pkg.sv
source/serial_frame_pkg.sv
source/input_conditioner.sv
source/guide_timer.sv
source/guide_fsm.sv
source/json_burst.sv
source/uart_tx.sv
source/guide_dog_top.sv
dv/guide_dog_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --timescale 1ns/1ps --top-module guide_dog_tb -f sim.f

status=0
out=$(./obj_dir/Vguide_dog_tb 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1
